// File: include/audio_defs.svh
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// audio timing and tone constants shared by the rtl

// clocks per audio sample
// 98.3 MHz board clock / 8192 gives roughly 12 kHz audio
`define AUDIO_SAMPLE_DIV 8192

// phase increments for a 32-bit accumulator stepped at the sample rate
// incr = 2^32 * f_tone / f_sample, with f_sample taken as 12 kHz

// tone a, 750 Hz -> 2^32 / 16
`define AUDIO_TONE_A_INCR 32'd268435456

// tone b, 440 Hz -> 157482134.2, truncated
`define AUDIO_TONE_B_INCR 32'd157482134

`endif

// File: rtl/audio_pkg.sv
package audio_pkg;

  // signed pcm amplitude, full scale +/-127 out of the sine table
  typedef logic signed [7:0] sample_t;

  // phase accumulator word, top 6 bits index the sine table
  typedef logic [31:0] phase_t;

  // volume, 7 loudest and 0 quietest (shift right by 7 - volume)
  typedef logic [2:0] volume_t;

  // what the speaker plays
  typedef logic [1:0] src_sel_t;

  // source select codes
  localparam src_sel_t SRC_TONE_A  = 2'd0;  // 750 Hz tone
  localparam src_sel_t SRC_TONE_B  = 2'd1;  // 440 Hz tone
  localparam src_sel_t SRC_MIX     = 2'd2;  // average of both tones
  localparam src_sel_t SRC_SILENCE = 2'd3;  // output held at zero

endpackage

// File: rtl/audio_ctrl.sv
`timescale 1ns/100ps
`include "audio_defs.svh"

module audio_ctrl #(
  parameter int unsigned SAMPLE_DIV = `AUDIO_SAMPLE_DIV  // clocks per sample
) (
  input  logic                clk_m,
  input  logic                rst_n,
  input  logic [15:0]         sw,
  output logic                sample_tick,  // one pulse per sample period
  output logic                pwm_step,     // one pulse every 4 clocks
  output audio_pkg::src_sel_t src_sel,      // held for a whole sample
  output audio_pkg::volume_t  volume
);

  localparam int unsigned CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

  // only the six switches that matter get synchronized
  // bit layout {vol[2:0], mix, tone_b, tone_a}
  logic [5:0]          sw_meta;
  logic [5:0]          sw_sync;
  logic [CNT_W-1:0]    div_cnt;  // sample divider
  logic [1:0]          pwm_cnt;  // pwm prescaler
  audio_pkg::src_sel_t src_dec;

  // two flop synchronizer, switches are asynchronous to clk_m
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= {sw[15:13], sw[2:0]};
      sw_sync <= sw_meta;
    end
  end

  // priority decode, lowest switch wins
  always_comb begin
    if (sw_sync[0])
      src_dec = audio_pkg::SRC_TONE_A;
    else if (sw_sync[1])
      src_dec = audio_pkg::SRC_TONE_B;
    else if (sw_sync[2])
      src_dec = audio_pkg::SRC_MIX;
    else
      src_dec = audio_pkg::SRC_SILENCE;
  end

  // sample divider, settings are sampled on the same edge that raises the tick
  // so the whole pipeline for one sample sees one consistent setting
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt     <= '0;
      sample_tick <= 1'b0;
      src_sel     <= audio_pkg::SRC_SILENCE;  // quiet until first tick
      volume      <= '0;
    end else if (div_cnt == CNT_W'(SAMPLE_DIV - 1)) begin
      div_cnt     <= '0;
      sample_tick <= 1'b1;
      src_sel     <= src_dec;
      volume      <= sw_sync[5:3];  // sw[15:13]
    end else begin
      div_cnt     <= div_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  // pwm step at clk/4, registered so it first fires 4 clocks out of reset
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt  <= '0;
      pwm_step <= 1'b0;
    end else begin
      pwm_cnt  <= pwm_cnt + 1'b1;  // wraps every 4
      pwm_step <= (pwm_cnt == 2'd3);
    end
  end

endmodule

// File: rtl/sine_generator.sv
`timescale 1ns/100ps
`include "audio_defs.svh"

module sine_generator #(
  parameter audio_pkg::phase_t PHASE_INCR = `AUDIO_TONE_A_INCR  // 2^32 * f / fs
) (
  input  logic               clk_m,
  input  logic               rst_n,
  input  logic               step,       // advance one sample
  output audio_pkg::sample_t amp,        // registered amplitude
  output logic               amp_valid   // pulses the cycle after step
);

  audio_pkg::phase_t  phase;
  audio_pkg::phase_t  phase_next;
  logic [5:0]         idx;          // 64 points per period
  logic [4:0]         quarter_idx;  // 0..16 into the quarter table
  logic [6:0]         mag;
  audio_pkg::sample_t amp_next;

  // round(127 * sin(2*pi*k/64)) for k = 0..16
  function automatic logic [6:0] quarter_sine(input logic [4:0] k);
    logic [6:0] v;
    case (k)
      5'd0:    v = 7'd0;
      5'd1:    v = 7'd12;
      5'd2:    v = 7'd25;
      5'd3:    v = 7'd37;
      5'd4:    v = 7'd49;
      5'd5:    v = 7'd60;
      5'd6:    v = 7'd71;
      5'd7:    v = 7'd81;
      5'd8:    v = 7'd90;
      5'd9:    v = 7'd98;
      5'd10:   v = 7'd106;
      5'd11:   v = 7'd112;
      5'd12:   v = 7'd117;
      5'd13:   v = 7'd122;
      5'd14:   v = 7'd125;
      5'd15:   v = 7'd126;
      5'd16:   v = 7'd127;  // peak
      default: v = 7'd0;    // index never goes past 16
    endcase
    return v;
  endfunction

  always_comb begin
    phase_next = phase + PHASE_INCR;  // wraps naturally at 2^32
    idx        = phase_next[31:26];
    // quadrants 1 and 3 run the table backwards
    if (idx[4])
      quarter_idx = 5'd16 - {1'b0, idx[3:0]};
    else
      quarter_idx = {1'b0, idx[3:0]};
    mag = quarter_sine(quarter_idx);
    // second half period is the negative lobe
    if (idx[5])
      amp_next = -{1'b0, mag};
    else
      amp_next = {1'b0, mag};
  end

  // amplitude of the new phase lands together with the phase update
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= '0;
      amp       <= '0;
      amp_valid <= 1'b0;
    end else begin
      if (step) begin
        phase <= phase_next;
        amp   <= amp_next;
      end
      amp_valid <= step;
    end
  end

endmodule

// File: rtl/volume_scaler.sv
`timescale 1ns/100ps

module volume_scaler (
  input  logic                clk_m,
  input  logic                rst_n,
  input  audio_pkg::sample_t  tone_a,
  input  audio_pkg::sample_t  tone_b,
  input  logic                amp_valid,  // from tone a, both tones step together
  input  audio_pkg::src_sel_t src_sel,
  input  audio_pkg::volume_t  volume,
  output audio_pkg::sample_t  sample,
  output logic                sample_valid
);

  logic [8:0]         mix_sum;  // one extra bit so the sum cannot overflow
  audio_pkg::sample_t mix_avg;
  audio_pkg::sample_t src_val;
  audio_pkg::sample_t scaled;
  logic [2:0]         shift;

  always_comb begin
    mix_sum = {tone_a[7], tone_a} + {tone_b[7], tone_b};  // sign extended add
    mix_avg = mix_sum[8:1];  // >>> 1 of the 9-bit sum
    case (src_sel)
      audio_pkg::SRC_TONE_A: src_val = tone_a;
      audio_pkg::SRC_TONE_B: src_val = tone_b;
      audio_pkg::SRC_MIX:    src_val = mix_avg;
      default:               src_val = '0;  // silence
    endcase
    shift  = 3'd7 - volume;
    scaled = src_val >>> shift;  // arithmetic, keeps the sign
  end

  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      sample       <= '0;
      sample_valid <= 1'b0;
    end else begin
      if (amp_valid)
        sample <= scaled;
      sample_valid <= amp_valid;  // two clocks behind sample_tick
    end
  end

endmodule

// File: rtl/pwm_modulator.sv
`timescale 1ns/100ps

module pwm_modulator (
  input  logic               clk_m,
  input  logic               rst_n,
  input  logic               step,     // frame counter advance
  input  audio_pkg::sample_t level,    // signed sample to reproduce
  output logic               pwm_out
);

  logic [7:0] frame_cnt;  // 256 steps per frame
  logic [7:0] level_q;    // offset binary duty for the current frame

  // level is picked up only as the counter wraps so the duty never changes
  // partway through a frame
  always_ff @(posedge clk_m or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
      level_q   <= '0;  // pins stay low until the first frame boundary
    end else if (step) begin
      frame_cnt <= frame_cnt + 1'b1;
      if (frame_cnt == 8'hff)
        level_q <= {~level[7], level[6:0]};  // sample + 128
    end
  end

  // high for level_q steps at the start of each frame
  assign pwm_out = (frame_cnt < level_q);

endmodule

// File: rtl/audio_top.sv
`timescale 1ns/100ps
`include "audio_defs.svh"

module audio_top #(
  parameter int unsigned SAMPLE_DIV = `AUDIO_SAMPLE_DIV
) (
  input  logic               clk_m,
  input  logic               rst_n,
  input  logic [15:0]        sw,
  output logic               spkl,          // speaker pins, same signal on both
  output logic               spkr,
  output audio_pkg::sample_t sample_out,    // monitor tap of the scaled sample
  output logic               sample_valid
);

  logic                sample_tick;
  logic                pwm_step;
  audio_pkg::src_sel_t src_sel;
  audio_pkg::volume_t  volume;
  audio_pkg::sample_t  tone_a;
  audio_pkg::sample_t  tone_b;
  logic                amp_valid_a;
  logic                pwm_sig;

  audio_ctrl #(.SAMPLE_DIV(SAMPLE_DIV)) ctrl (
    .clk_m       (clk_m),
    .rst_n       (rst_n),
    .sw          (sw),
    .sample_tick (sample_tick),
    .pwm_step    (pwm_step),
    .src_sel     (src_sel),
    .volume      (volume)
  );

  sine_generator #(.PHASE_INCR(`AUDIO_TONE_A_INCR)) sine_a (  // 750 Hz
    .clk_m     (clk_m),
    .rst_n     (rst_n),
    .step      (sample_tick),
    .amp       (tone_a),
    .amp_valid (amp_valid_a)
  );

  // same step as sine_a, its valid is redundant
  sine_generator #(.PHASE_INCR(`AUDIO_TONE_B_INCR)) sine_b (  // 440 Hz
    .clk_m     (clk_m),
    .rst_n     (rst_n),
    .step      (sample_tick),
    .amp       (tone_b),
    .amp_valid ()
  );

  volume_scaler scaler (
    .clk_m        (clk_m),
    .rst_n        (rst_n),
    .tone_a       (tone_a),
    .tone_b       (tone_b),
    .amp_valid    (amp_valid_a),
    .src_sel      (src_sel),
    .volume       (volume),
    .sample       (sample_out),
    .sample_valid (sample_valid)
  );

  pwm_modulator pwm (
    .clk_m   (clk_m),
    .rst_n   (rst_n),
    .step    (pwm_step),
    .level   (sample_out),
    .pwm_out (pwm_sig)
  );

  assign spkl = pwm_sig;
  assign spkr = pwm_sig;  // mono, both channels identical

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD  = 20,  // ns, 40 ns clock
  parameter int RESET_CYCLES = 3
) (
  output logic clk_m,
  output logic rst_n
);

  initial begin
    clk_m = 1'b0;
    forever #(HALF_PERIOD) clk_m = ~clk_m;
  end

  // reset drops out 1 ns after a rising edge, same as the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_m);
    #1 rst_n = 1'b1;
  end

endmodule

// File: testbench/audio_checker.sv
`timescale 1ns/100ps

module audio_checker (
  input logic clk_m,
  input logic rst_n,
  input logic spkl,
  input logic spkr,
  input logic sample_valid
);

  int unsigned fail_cnt = 0;  // polled by the testbench every cycle

  // one valid per sample period, never two in a row
  valid_single: assert property (@(posedge clk_m) disable iff (!rst_n)
    sample_valid |=> !sample_valid)
    else begin
      fail_cnt++;
      $error("sample_valid high on two consecutive cycles");
    end

  // mono output, both pins come from one pwm
  spk_equal: assert property (@(posedge clk_m) spkl == spkr)
    else begin
      fail_cnt++;
      $error("spkl and spkr differ");
    end

  // async reset keeps the speaker and the monitor strobe quiet
  reset_quiet: assert property (@(posedge clk_m)
    !rst_n |-> (!spkl && !spkr && !sample_valid))
    else begin
      fail_cnt++;
      $error("output active during reset");
    end

endmodule

// File: testbench/audio_tb.sv
`timescale 1ns/100ps
`include "audio_defs.svh"

module audio_tb;

  localparam int unsigned SAMPLE_DIV    = 64;
  localparam int unsigned FRAME_CLKS    = 1024;  // 256 pwm steps of 4 clocks
  localparam int unsigned NUM_SAMPLES   = 400;
  localparam int unsigned VALID_TIMEOUT = 2 * SAMPLE_DIV;
  localparam real         PI            = 3.14159265358979;

  logic               clk_m;
  logic               rst_n;
  logic [15:0]        sw;
  logic               spkl;
  logic               spkr;
  audio_pkg::sample_t sample_out;
  logic               sample_valid;

  // reference model state as it stands after edge cyc
  int unsigned         cyc;
  int unsigned         samples_seen;
  int unsigned         high_cnt;      // spkl high clocks in the current frame
  int unsigned         high_cnt_r;    // spkr high clocks in the current frame
  audio_pkg::sample_t  sine_tbl [64];
  logic [15:0]         sw_prev;       // sw as the next edge will sample it
  logic [15:0]         sw_meta_m;
  logic [15:0]         sw_sync_m;
  audio_pkg::src_sel_t src_m;
  audio_pkg::volume_t  vol_m;
  audio_pkg::phase_t   phase_a_m;
  audio_pkg::phase_t   phase_b_m;
  audio_pkg::sample_t  tone_a_m;
  audio_pkg::sample_t  tone_b_m;
  audio_pkg::sample_t  sample_m;
  logic [7:0]          level_m;       // pwm duty of the current frame

  tb_clock #(.HALF_PERIOD(20), .RESET_CYCLES(3)) clk_gen (.clk_m(clk_m), .rst_n(rst_n));

  audio_top #(.SAMPLE_DIV(SAMPLE_DIV)) UUT (
    .clk_m        (clk_m),
    .rst_n        (rst_n),
    .sw           (sw),
    .spkl         (spkl),
    .spkr         (spkr),
    .sample_out   (sample_out),
    .sample_valid (sample_valid)
  );

  bind audio_top audio_checker chk (
    .clk_m(clk_m), .rst_n(rst_n), .spkl(spkl), .spkr(spkr), .sample_valid(sample_valid)
  );

  task automatic fail_now();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_sample(input audio_pkg::sample_t actual,
                              input audio_pkg::sample_t expected, input string name);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      fail_now();
    end
  endtask

  task automatic check_duty(input logic [7:0] actual, input logic [7:0] expected,
                            input string name);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      fail_now();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
      fail_now();
    end
  endtask

  // 64 point sine with 127 full scale and rounding to nearest
  task automatic build_table();
    real v;
    for (int n = 0; n < 64; n++) begin
      v = 127.0 * $sin(2.0 * PI * n / 64.0);
      if (v >= 0.0)
        sine_tbl[n] = audio_pkg::sample_t'($rtoi(v + 0.5));
      else
        sine_tbl[n] = audio_pkg::sample_t'(-$rtoi(0.5 - v));
    end
  endtask

  function automatic audio_pkg::src_sel_t decode_src(input logic [15:0] s);
    if (s[0])
      return audio_pkg::SRC_TONE_A;
    if (s[1])
      return audio_pkg::SRC_TONE_B;
    if (s[2])
      return audio_pkg::SRC_MIX;
    return audio_pkg::SRC_SILENCE;
  endfunction

  function automatic audio_pkg::sample_t scale_sample(
    input audio_pkg::src_sel_t src, input audio_pkg::volume_t vol,
    input audio_pkg::sample_t a, input audio_pkg::sample_t b);
    int sel;
    case (src)
      audio_pkg::SRC_TONE_A: sel = a;
      audio_pkg::SRC_TONE_B: sel = b;
      audio_pkg::SRC_MIX:    sel = (int'(a) + int'(b)) >>> 1;  // floor average
      default:               sel = 0;
    endcase
    return audio_pkg::sample_t'(sel >>> (7 - int'(vol)));
  endfunction

  // random source with the priority bits set on purpose and noise elsewhere
  function automatic logic [15:0] random_switches();
    logic [15:0] s;
    s = 16'($urandom);
    case ($urandom_range(3, 0))
      0:       s[0]   = 1'b1;     // tone a
      1:       s[1:0] = 2'b10;    // tone b
      2:       s[2:0] = 3'b100;   // mix
      default: s[2:0] = 3'b000;   // silence
    endcase
    if ($urandom_range(3, 0) == 0)
      s[15:13] = 3'd7;  // full volume fairly often
    return s;
  endfunction

  // advance the model by one edge and compare mid cycle
  task automatic step_cycle();
    @(negedge clk_m);
    cyc++;
    if (cyc > SAMPLE_DIV && cyc % SAMPLE_DIV == 2)
      sample_m = scale_sample(src_m, vol_m, tone_a_m, tone_b_m);
    if (cyc > SAMPLE_DIV && cyc % SAMPLE_DIV == 1) begin  // tones step after the tick
      phase_a_m += `AUDIO_TONE_A_INCR;
      phase_b_m += `AUDIO_TONE_B_INCR;
      tone_a_m   = sine_tbl[phase_a_m[31:26]];
      tone_b_m   = sine_tbl[phase_b_m[31:26]];
    end
    if (cyc % SAMPLE_DIV == 0) begin  // tick edge latches the synchronized settings
      src_m = decode_src(sw_sync_m);
      vol_m = sw_sync_m[15:13];
    end
    if (cyc > FRAME_CLKS && cyc % FRAME_CLKS == 1)
      level_m = 8'(int'(sample_m) + 128);  // new frame picks up the held sample
    sw_sync_m = sw_meta_m;
    sw_meta_m = sw_prev;
    sw_prev   = sw;

    check_flag(sample_valid, (cyc > SAMPLE_DIV && cyc % SAMPLE_DIV == 2), "sample_valid");
    check_sample(sample_out, sample_m, "sample_out");
    if (UUT.chk.fail_cnt != 0) begin
      $display("an assertion in the bound checker failed at %0t", $time);
      fail_now();
    end
    if (spkl)
      high_cnt++;
    if (spkr)
      high_cnt_r++;
    if (cyc % FRAME_CLKS == 0) begin  // last clock of a frame
      if (high_cnt % 4 != 0 || high_cnt > 1020) begin
        $display("spkl high for %0d clocks in a frame, not a whole number of steps", high_cnt);
        fail_now();
      end
      check_duty(8'(high_cnt / 4), level_m, "spkl duty");
      check_duty(8'(high_cnt_r / 4), level_m, "spkr duty");
      high_cnt   = 0;
      high_cnt_r = 0;
    end
  endtask

  // switch changes land at random points inside sample periods
  initial begin
    int unsigned seed_ret;
    int unsigned gap;
    seed_ret = $urandom(32'h086b_ae3b);
    sw = random_switches();
    for (int n = 0; n < 1000; n++) begin
      gap = $urandom_range(160, 8);
      repeat (gap) @(posedge clk_m);
      #1 sw = random_switches();
    end
  end

  initial begin
    int unsigned wait_cnt;
    int unsigned valid_wait;
    cyc          = 0;
    samples_seen = 0;
    high_cnt     = 0;
    high_cnt_r   = 0;
    sw_meta_m    = '0;
    sw_sync_m    = '0;
    src_m        = audio_pkg::SRC_SILENCE;
    vol_m        = '0;
    phase_a_m    = '0;
    phase_b_m    = '0;
    tone_a_m     = '0;
    tone_b_m     = '0;
    sample_m     = '0;
    level_m      = '0;  // frame 0 runs at zero duty
    build_table();

    wait_cnt = 0;
    @(negedge clk_m);
    while (rst_n !== 1'b1) begin
      if (wait_cnt == 10) begin
        $display("reset was never released");
        fail_now();
      end
      wait_cnt++;
      @(negedge clk_m);
    end
    // nothing has moved yet in the first cycle out of reset
    check_sample(sample_out, 8'sd0, "sample_out");
    check_flag(sample_valid, 1'b0, "sample_valid");
    check_flag(spkl, 1'b0, "spkl");
    check_flag(spkr, 1'b0, "spkr");
    sw_prev = sw;

    while (samples_seen < NUM_SAMPLES) begin
      valid_wait = 0;
      step_cycle();
      while (sample_valid !== 1'b1) begin
        if (valid_wait == VALID_TIMEOUT) begin
          $display("no sample_valid within %0d clocks", VALID_TIMEOUT);
          fail_now();
        end
        valid_wait++;
        step_cycle();
      end
      samples_seen++;
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
rtl/audio_pkg.sv
rtl/audio_ctrl.sv
rtl/sine_generator.sv
rtl/volume_scaler.sv
rtl/pwm_modulator.sv
rtl/audio_top.sv
testbench/tb_clock.sv
testbench/audio_checker.sv
testbench/audio_tb.sv

// File: Bender.yml
package:
  name: audio_tone

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/audio_pkg.sv
      - rtl/audio_ctrl.sv
      - rtl/sine_generator.sv
      - rtl/volume_scaler.sv
      - rtl/pwm_modulator.sv
      - rtl/audio_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_clock.sv
      - testbench/audio_checker.sv
      - testbench/audio_tb.sv
